// ==== vlog.f ====
+incdir+src
src/wb_pkg.sv
src/dram_pkg.sv
src/wb_fifo.sv
src/wb_req_decode.sv
src/wb_line_packer.sv
src/wb_dram_writer.sv
src/wb_top.sv
bench/wb_checker.sv
bench/wb_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = wb_tb
FILELIST = vlog.f
LOG = sim.log

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== bench/wb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module wb_tb import wb_pkg::*, dram_pkg::*; ();
	localparam int num_jobs = 5;
	localparam int ack_limit = 20000;
	localparam int done_limit = 50000;

	// Each entry is a job and the cache lines per row it should need.
	wb_job_t jobs [num_jobs] = '{
		'{'{32'h1000_0000, 10'd64, 4'd1}, 4'd1},
		'{'{32'h2000_0040, 10'd100, 4'd2}, 4'd2},
		'{'{32'h3000_0000, 10'd512, 4'd8}, 4'd8},
		'{'{32'h0000_8000, 10'd1, 4'd3}, 4'd1},
		'{'{32'h4000_1000, 10'd200, 4'd4}, 4'd4}
	};

	logic clk;
	logic rst_n;
	logic req;
	host_req_t host_req;
	logic ack;
	buf_addr_t buf_addr;
	logic [7:0] buf_data = 8'h00;
	logic dram_cmd_valid;
	dram_cmd_t dram_cmd;
	logic dram_wvalid;
	logic [`WB_CL_BYTES*8-1:0] dram_wdata;
	logic dram_ready = 1'b0;
	logic dram_done = 1'b0;
	logic job_done;
	logic end_check;
	logic checked;
	logic [31:0] total_beats;
	int mismatches;
	int timeouts;
	int done_seen = 0;
	int seed = 73;
	buf_addr_t rd_addr = '0;
	int burst_left = 0;
	int done_wait = 0;
	logic fire_done = 1'b0;

	wb_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.host_req(host_req),
		.ack(ack),
		.buf_addr(buf_addr),
		.buf_data(buf_data),
		.dram_cmd_valid(dram_cmd_valid),
		.dram_cmd(dram_cmd),
		.dram_wvalid(dram_wvalid),
		.dram_wdata(dram_wdata),
		.dram_ready(dram_ready),
		.dram_done(dram_done),
		.job_done(job_done)
	);

	wb_checker #(.num_jobs(num_jobs)) i_checker (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.host_req(host_req),
		.ack(ack),
		.dram_cmd_valid(dram_cmd_valid),
		.dram_cmd(dram_cmd),
		.dram_wvalid(dram_wvalid),
		.dram_wdata(dram_wdata),
		.dram_ready(dram_ready),
		.dram_done(dram_done),
		.job_done(job_done),
		.end_check(end_check),
		.total_beats(total_beats),
		.errors(mismatches),
		.checked(checked)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// The buffer holds row * 37 + column and answers one cycle after the address.
	always @(negedge clk)
		rd_addr <= buf_addr;

	always @(posedge clk) begin
		#1;
		buf_data <= 8'(32'(rd_addr.row) * 37 + 32'(rd_addr.col));
	end

	always @(negedge clk) begin
		fire_done = (done_wait == 1);
		if (done_wait != 0)
			done_wait = done_wait - 1;
		if (dram_cmd_valid)
			burst_left = int'(dram_cmd.len);
		if (dram_wvalid && dram_ready) begin
			burst_left = burst_left - 1;
			if (burst_left == 0)
				done_wait = 3; // The burst completes a few cycles after its last beat.
		end
	end

	always @(posedge clk) begin
		#1;
		dram_ready <= ($random(seed) & 3) != 0;
		dram_done <= fire_done;
	end

	always @(negedge clk)
		if (job_done)
			done_seen <= done_seen + 1;

	// Runs the full four-phase handshake and returns just after a rising edge.
	task automatic send_job(host_req_t r);
		int t;
		host_req = r;
		req = 1'b1;
		t = 0;
		@(negedge clk);
		while (!ack && t < ack_limit) begin
			@(negedge clk);
			t++;
		end
		if (!ack) begin
			timeouts++;
			$display("Timeout waiting for ack to rise on job at %h", r.base_addr);
		end
		@(posedge clk);
		#1;
		req = 1'b0;
		t = 0;
		@(negedge clk);
		while (ack && t < 100) begin
			@(negedge clk);
			t++;
		end
		if (ack) begin
			timeouts++;
			$display("Timeout waiting for ack to fall on job at %h", r.base_addr);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic wait_jobs_done();
		int t;
		t = 0;
		while (done_seen < num_jobs && t < done_limit) begin
			@(posedge clk);
			t++;
		end
		if (done_seen < num_jobs) begin
			timeouts++;
			$display("Timeout with %0d of %0d jobs completed", done_seen, num_jobs);
		end
	endtask

	task automatic wait_checked();
		int t;
		t = 0;
		while (!checked && t < 10) begin
			@(posedge clk);
			t++;
		end
		if (!checked) begin
			timeouts++;
			$display("Timeout waiting for the checker to finish its final checks");
		end
	endtask

	initial begin
		int i;
		rst_n = 1'b0;
		req = 1'b0;
		host_req = '0;
		end_check = 1'b0;
		timeouts = 0;
		total_beats = '0;
		for (i = 0; i < num_jobs; i++)
			total_beats = total_beats + 32'(jobs[i].req.height) * 32'(jobs[i].lines);
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (4) @(posedge clk); // Quiet cycles before the first request.
		#1;
		for (i = 0; i < num_jobs; i++)
			send_job(jobs[i].req);
		wait_jobs_done();
		@(posedge clk);
		#1;
		end_check = 1'b1;
		wait_checked();
		$display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/wb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module wb_checker import wb_pkg::*, dram_pkg::*; #(
	parameter int num_jobs = 1
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic req,
	input wire host_req_t host_req,
	input wire logic ack,
	input wire logic dram_cmd_valid,
	input wire dram_cmd_t dram_cmd,
	input wire logic dram_wvalid,
	input wire logic [`WB_CL_BYTES*8-1:0] dram_wdata,
	input wire logic dram_ready,
	input wire logic dram_done,
	input wire logic job_done,
	input wire logic end_check,
	input wire logic [31:0] total_beats,
	output int errors,
	output logic checked
);
	logic [31:0] exp_addr [$];
	logic [3:0] exp_len [$];
	logic [`WB_CL_BYTES*8-1:0] exp_data [$];
	int exp_rows [$];
	logic seen_req;
	logic ack_q;
	logic exp_done;
	int cur_len;
	int burst_beats;
	int beats;
	int done_cnt;
	int rows_done;

	// Byte k of a line sits k bytes below the top, and columns past the width read as zero.
	function automatic logic [`WB_CL_BYTES*8-1:0] expected_line(int row, int first_col,
		int width);
		logic [`WB_CL_BYTES*8-1:0] data;
		int k;
		int col;
		data = '0;
		for (k = 0; k < `WB_CL_BYTES; k++) begin
			col = first_col + k;
			if (col < width)
				data[`WB_CL_BYTES*8-1-8*k -: 8] = 8'((row % `WB_BUF_ROWS) * 37 + col);
		end
		return data;
	endfunction

	task automatic record_job(host_req_t r);
		int lines;
		int row;
		int l;
		lines = (int'(r.width) + `WB_CL_BYTES - 1) / `WB_CL_BYTES;
		exp_rows.push_back(int'(r.height));
		for (row = 0; row < int'(r.height); row++) begin
			exp_addr.push_back(r.base_addr + 32'(row * lines * `WB_CL_BYTES));
			exp_len.push_back(4'(lines));
			for (l = 0; l < lines; l++)
				exp_data.push_back(expected_line(row, l * `WB_CL_BYTES, int'(r.width)));
		end
	endtask

	task automatic close_burst();
		if (cur_len != 0 && burst_beats != cur_len) begin
			errors++;
			$display("Mismatch burst beats: got %h, expected %h", burst_beats, cur_len);
		end
		cur_len = 0;
		burst_beats = 0;
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			errors = 0;
			checked = 1'b0;
			seen_req = 1'b0;
			ack_q = 1'b0;
			exp_done = 1'b0;
			cur_len = 0;
			burst_beats = 0;
			beats = 0;
			done_cnt = 0;
			rows_done = 0;
		end else begin
			if (!seen_req && (ack || dram_cmd_valid || dram_wvalid || job_done)) begin
				errors++;
				$display("An output went high before the first request at %0t", $time);
			end
			if (req)
				seen_req = 1'b1;
			if (req && ack && !ack_q)
				record_job(host_req);
			ack_q = ack;
			if (dram_cmd_valid) begin
				close_burst();
				if (exp_addr.size() == 0) begin
					errors++;
					$display("Unexpected DRAM command to %h", dram_cmd.addr);
				end else begin
					if (dram_cmd.addr != exp_addr[0]) begin
						errors++;
						$display("Mismatch dram_cmd.addr: got %h, expected %h",
							dram_cmd.addr, exp_addr[0]);
					end
					if (dram_cmd.len != exp_len[0]) begin
						errors++;
						$display("Mismatch dram_cmd.len: got %h, expected %h",
							dram_cmd.len, exp_len[0]);
					end
					cur_len = int'(exp_len[0]);
					void'(exp_addr.pop_front());
					void'(exp_len.pop_front());
				end
			end
			if (dram_wvalid && dram_ready) begin
				burst_beats++;
				beats++;
				if (exp_data.size() == 0) begin
					errors++;
					$display("Unexpected DRAM beat with data %h", dram_wdata);
				end else if (dram_wdata != exp_data[0]) begin
					errors++;
					$display("Mismatch dram_wdata: got %h, expected %h", dram_wdata, exp_data[0]);
				end
				if (exp_data.size() != 0)
					void'(exp_data.pop_front());
			end
			// Every row ends on one dram_done, and the job's last row ends the job.
			exp_done = 1'b0;
			if (dram_done) begin
				rows_done++;
				if (exp_rows.size() != 0 && rows_done == exp_rows[0]) begin
					exp_done = 1'b1;
					rows_done = 0;
					void'(exp_rows.pop_front());
				end
			end
			if (job_done != exp_done) begin
				errors++;
				$display("Mismatch job_done: got %h, expected %h", job_done, exp_done);
			end
			if (job_done)
				done_cnt++;
			if (end_check && !checked) begin
				close_burst();
				if (exp_addr.size() != 0 || exp_data.size() != 0) begin
					errors++;
					$display("%0d commands and %0d beats were expected but never arrived",
						exp_addr.size(), exp_data.size());
				end
				if (done_cnt != num_jobs) begin
					errors++;
					$display("Mismatch job_done count: got %h, expected %h", done_cnt, num_jobs);
				end
				if (beats != int'(total_beats)) begin
					errors++;
					$display("Mismatch beat total: got %h, expected %h", beats, total_beats);
				end
				checked = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/wb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module wb_top import wb_pkg::*, dram_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic req,
	input wire host_req_t host_req,
	output logic ack,
	output buf_addr_t buf_addr,
	input wire logic [7:0] buf_data,
	output logic dram_cmd_valid,
	output dram_cmd_t dram_cmd,
	output logic dram_wvalid,
	output logic [`WB_CL_BYTES*8-1:0] dram_wdata,
	input wire logic dram_ready,
	input wire logic dram_done,
	output logic job_done
);
	wb_job_t job_in;
	wb_job_t job_head;
	logic job_push;
	logic job_full;
	logic job_pop;
	logic job_empty;

	dram_line_t line_in;
	dram_line_t line_head;
	logic line_push;
	logic line_full;
	logic line_pop;
	logic line_empty;

	wb_req_decode i_decode (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.host_req(host_req),
		.ack(ack),
		.job(job_in),
		.job_push(job_push),
		.job_full(job_full)
	);

	wb_fifo #(.item_t(wb_job_t), .depth(`WB_JOB_FIFO_DEPTH)) i_job_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(job_push),
		.din(job_in),
		.full(job_full),
		.pop(job_pop),
		.dout(job_head),
		.empty(job_empty)
	);

	wb_line_packer i_packer (
		.clk(clk),
		.rst_n(rst_n),
		.job(job_head),
		.job_empty(job_empty),
		.job_pop(job_pop),
		.buf_addr(buf_addr),
		.buf_data(buf_data),
		.line(line_in),
		.line_push(line_push),
		.line_full(line_full)
	);

	wb_fifo #(.item_t(dram_line_t), .depth(`WB_LINE_FIFO_DEPTH)) i_line_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(line_push),
		.din(line_in),
		.full(line_full),
		.pop(line_pop),
		.dout(line_head),
		.empty(line_empty)
	);

	wb_dram_writer i_writer (
		.clk(clk),
		.rst_n(rst_n),
		.line(line_head),
		.line_empty(line_empty),
		.line_pop(line_pop),
		.dram_cmd_valid(dram_cmd_valid),
		.dram_cmd(dram_cmd),
		.dram_wvalid(dram_wvalid),
		.dram_wdata(dram_wdata),
		.dram_ready(dram_ready),
		.dram_done(dram_done),
		.job_done(job_done)
	);

endmodule

`default_nettype wire

// ==== src/wb_dram_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module wb_dram_writer import dram_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire dram_line_t line,
	input wire logic line_empty,
	output logic line_pop,
	output logic dram_cmd_valid,
	output dram_cmd_t dram_cmd,
	output logic dram_wvalid,
	output logic [`WB_CL_BYTES*8-1:0] dram_wdata,
	input wire logic dram_ready,
	input wire logic dram_done,
	output logic job_done
);
	typedef enum logic [1:0] {st_idle, st_cmd, st_send, st_wait_done} state_e;

	state_e state;
	logic [3:0] beats_left;
	logic job_last;
	logic beat;

	// The opening line stays at the queue head through the command cycle.
	assign dram_cmd_valid = (state == st_cmd);
	assign dram_cmd.addr = line.addr;
	assign dram_cmd.len = line.len;

	assign dram_wvalid = (state == st_send) && !line_empty;
	assign dram_wdata = line.data;
	assign beat = dram_wvalid && dram_ready;
	assign line_pop = beat; // Each accepted beat retires one line.

	assign job_done = (state == st_wait_done) && dram_done && job_last;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			beats_left <= '0;
			job_last <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (!line_empty && line.first)
						state <= st_cmd;
				end
				st_cmd: begin
					beats_left <= line.len;
					state <= st_send;
				end
				st_send: begin
					if (beat) begin
						job_last <= line.last;
						if (beats_left == 4'd1)
							state <= st_wait_done;
						else
							beats_left <= beats_left - 4'd1;
					end
				end
				st_wait_done: begin
					// The next row may not start until this burst is done.
					if (dram_done)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/wb_line_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module wb_line_packer import wb_pkg::*, dram_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire wb_job_t job,
	input wire logic job_empty,
	output logic job_pop,
	output buf_addr_t buf_addr,
	input wire logic [7:0] buf_data,
	output dram_line_t line,
	output logic line_push,
	input wire logic line_full
);
	localparam int cl_shift = $clog2(`WB_CL_BYTES);
	localparam int cnt_w = cl_shift + 1;
	localparam int row_w = $clog2(`WB_BUF_ROWS);
	localparam int col_w = $clog2(`WB_BUF_DEPTH);
	localparam int line_w = col_w - cl_shift;

	typedef enum logic [1:0] {st_idle, st_load, st_push} state_e;

	state_e state;
	logic [3:0] row;
	logic [3:0] line_idx;
	logic [cnt_w-1:0] byte_cnt;
	logic [31:0] row_addr;
	logic [col_w-1:0] col;
	logic issue;
	logic rd_pending;
	logic rd_keep;
	logic [`WB_CL_BYTES*8-1:0] line_data;
	logic last_line;
	logic last_row;
	logic accepted;

	assign col = {line_idx[line_w-1:0], byte_cnt[cl_shift-1:0]};
	assign issue = (state == st_load) && (byte_cnt != cnt_w'(`WB_CL_BYTES));
	assign buf_addr.row = row[row_w-1:0]; // Rows wrap modulo the buffer height.
	assign buf_addr.col = col;

	assign last_line = (line_idx == job.lines - 4'd1);
	assign last_row = (row == job.req.height - 4'd1);
	assign accepted = (state == st_push) && !line_full;
	assign line_push = accepted;
	assign job_pop = accepted && last_line && last_row;

	assign line.data = line_data;
	assign line.addr = row_addr + (32'(line_idx) << cl_shift);
	assign line.len = job.lines;
	assign line.first = (line_idx == 4'd0);
	assign line.last = last_line && last_row;

	// The buffer answers one cycle after the address, so the width check
	// travels alongside the read.
	always_ff @(posedge clk) begin
		rd_keep <= ({1'b0, col} < job.req.width);
		if (rd_pending)
			line_data <= {line_data[`WB_CL_BYTES*8-9:0], rd_keep ? buf_data : 8'h00};
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			row <= '0;
			line_idx <= '0;
			byte_cnt <= '0;
			row_addr <= '0;
			rd_pending <= 1'b0;
		end else begin
			rd_pending <= issue;
			case (state)
				st_idle: begin
					if (!job_empty) begin
						row <= '0;
						line_idx <= '0;
						byte_cnt <= '0;
						row_addr <= job.req.base_addr;
						state <= st_load;
					end
				end
				st_load: begin
					if (issue)
						byte_cnt <= byte_cnt + 1'b1;
					else
						state <= st_push; // Last byte shifts in this cycle.
				end
				st_push: begin
					if (accepted) begin
						byte_cnt <= '0;
						if (last_line) begin
							line_idx <= '0;
							row <= row + 4'd1;
							row_addr <= row_addr + (32'(job.lines) << cl_shift);
							state <= last_row ? st_idle : st_load;
						end else begin
							line_idx <= line_idx + 4'd1;
							state <= st_load;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/wb_req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module wb_req_decode import wb_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic req,
	input wire host_req_t host_req,
	output logic ack,
	output wb_job_t job,
	output logic job_push,
	input wire logic job_full
);
	localparam int cl_shift = $clog2(`WB_CL_BYTES);

	typedef enum logic {st_idle, st_ack} state_e;

	state_e state;
	logic accept;

	// Only idle takes a request, so each handshake yields exactly one job.
	assign accept = (state == st_idle) && req && !job_full;
	assign ack = (state == st_ack);

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			job_push <= 1'b0;
		end else begin
			job_push <= accept; // Push lands in the first ack cycle.
			case (state)
				st_idle: begin
					if (accept)
						state <= st_ack;
				end
				st_ack: begin
					if (!req)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Lines per row is the width in cache lines, rounded up.
	always_ff @(posedge clk) begin
		if (accept) begin
			job.req <= host_req;
			job.lines <= 4'(host_req.width >> cl_shift)
				+ 4'(|host_req.width[cl_shift-1:0]);
		end
	end

endmodule

`default_nettype wire

// ==== src/wb_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_fifo #(
	parameter type item_t = logic,
	parameter int depth = 2
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic push,
	input wire item_t din,
	output logic full,
	input wire logic pop,
	output item_t dout,
	output logic empty
);
	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	item_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == cnt_w'(depth));
	assign empty = (count == '0);
	assign do_push = push && !full; // Writes into a full queue are ignored.
	assign do_pop = pop && !empty;
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/dram_pkg.sv ====
`default_nettype none

`include "wb_cfg.svh"

package dram_pkg;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0] len; // Burst length in lines.
	} dram_cmd_t;

	// One packed cache line with the tags the writer needs.
	typedef struct packed {
		logic [`WB_CL_BYTES*8-1:0] data; // First byte sits in the top byte.
		logic [31:0] addr;
		logic [3:0] len;
		logic first; // Opens a row burst.
		logic last; // Closes the job.
	} dram_line_t;

endpackage

`default_nettype wire

// ==== src/wb_pkg.sv ====
`default_nettype none

`include "wb_cfg.svh"

package wb_pkg;

	// Job as the host presents it.
	typedef struct packed {
		logic [31:0] base_addr;
		logic [9:0] width; // Row width in bytes from 1 to 512.
		logic [3:0] height; // Rows in the job from 1 to 8.
	} host_req_t;

	// Decoded job carried from decode to the packer.
	typedef struct packed {
		host_req_t req;
		logic [3:0] lines; // Cache lines per row.
	} wb_job_t;

	typedef struct packed {
		logic [$clog2(`WB_BUF_ROWS)-1:0] row;
		logic [$clog2(`WB_BUF_DEPTH)-1:0] col;
	} buf_addr_t;

endpackage

`default_nettype wire

// ==== src/wb_cfg.svh ====
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// One DRAM beat carries a whole cache line.
`define WB_CL_BYTES 64

// The source buffer holds one frame row per buffer row.
`define WB_BUF_DEPTH 512
`define WB_BUF_ROWS 8

`define WB_JOB_FIFO_DEPTH 2
`define WB_LINE_FIFO_DEPTH 4

`endif
